// ==== flist.f ====
+incdir+sim
common/net_pkg.sv
src/net_regs.sv
addr/addr_manager.sv
tx/tx_arbiter.sv
tx/tx_dest_select.sv
src/network_top.sv
sim/tb_network.sv

// ==== sim/tb_checks.svh ====
// --------------------------------------------------------------------------
// Testbench helpers, included inside tb_network. APB master tasks,
// bounded wait loops and compare tasks typed to the DUT types.
// --------------------------------------------------------------------------
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  // ------------------------------------------------------------------------
  // compare tasks, stop at first mismatch
  // ------------------------------------------------------------------------
  task automatic check_ip(input ip_addr_t got, input ip_addr_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_mac(input mac_addr_t got, input mac_addr_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_port(input udp_port_t got, input udp_port_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic check_proto(input tx_proto_e got, input tx_proto_e exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic check_state(input addr_state_e got, input addr_state_e exp,
                             input string what);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic check_data(input apb_data_t got, input apb_data_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic check_seconds(input logic [3:0] got, input logic [3:0] exp,
                               input string what);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp)
      abort_run($sformatf("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  // ------------------------------------------------------------------------
  // apb master, setup then one access cycle
  // ------------------------------------------------------------------------
  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
    @(posedge tx_clock);
    psel    <= 1'b1;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge tx_clock);
    penable <= 1'b1;
    @(negedge tx_clock);
    check_bit(pslverr, exp_err, $sformatf("pslverr writing offset %h", addr));
    @(posedge tx_clock);             // write lands here
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, input apb_data_t exp_data, input logic exp_err);
    @(posedge tx_clock);
    psel    <= 1'b1;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge tx_clock);
    penable <= 1'b1;
    @(negedge tx_clock);
    check_bit(pready, 1'b1, "pready");
    check_bit(pslverr, exp_err, $sformatf("pslverr reading offset %h", addr));
    if (!exp_err)
      check_data(prdata, exp_data, $sformatf("readback of offset %h", addr));
    @(posedge tx_clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // ------------------------------------------------------------------------
  // bounded waits, sampled on the falling edge
  // ------------------------------------------------------------------------
  localparam int SIG_FIXED_PENDING = 0;
  localparam int SIG_DHCP_PENDING  = 1;
  localparam int SIG_DHCP_TX       = 2;

  function automatic logic probe(input int sel);
    case (sel)
      SIG_FIXED_PENDING: probe = fixed_pending;
      SIG_DHCP_PENDING:  probe = dhcp_pending;
      default:           probe = dhcp_tx_enable;
    endcase
  endfunction

  task automatic wait_level(input int sel, input logic level, input int limit,
                            input string what, output int cycles);
    cycles = 0;
    @(negedge tx_clock);
    while (probe(sel) !== level) begin
      if (cycles >= limit)
        abort_run($sformatf("Timed out after %0d cycles waiting for %s", limit, what));
      @(negedge tx_clock);
      cycles++;
    end
  endtask

  // one-cycle request pulses until an address is fixed
  task automatic count_dhcp_pulses(input int limit, output int pulses);
    int waited;
    pulses = 0;
    waited = 0;
    @(negedge tx_clock);
    while (fixed_pending !== 1'b0) begin
      if (dhcp_tx_enable === 1'b1)
        pulses++;
      if (waited >= limit)
        abort_run($sformatf("Timed out after %0d cycles waiting for the DHCP fallback", limit));
      @(negedge tx_clock);
      waited++;
    end
  endtask

`endif

// ==== sim/tb_network.sv ====
// --------------------------------------------------------------------------
// Testbench for the network control core. Runs APB register access,
// static, DHCP lease and DHCP timeout address paths, link loss, and a
// table of transmit arbitration cases with header selection.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_network
  import net_pkg::*;
();

  localparam int SECOND_TICKS = 40;   // one simulated second

  logic        tx_clock = 1'b0;
  logic        rst_n;
  logic        psel, penable, pwrite, pready, pslverr;
  apb_addr_t   paddr;
  apb_data_t   pwdata, prdata;
  logic        link_up, dhcp_success, link_busy, run;
  logic [1:0]  link_speed;
  ip_addr_t    dhcp_ip, local_ip, icmp_ip, dhcp_ip_dest, udp_ip, dest_ip;
  lease_t      dhcp_lease;
  addr_state_e addr_state;
  logic        dhcp_tx_enable, dhcp_rx_enable, dhcp_pending, fixed_pending, speed_1gb;
  logic [3:0]  dhcp_seconds;
  logic        arp_tx_request, icmp_tx_request, dhcp_tx_request, udp_tx_request;
  tx_proto_e   tx_protocol;
  logic        tx_start, arp_tx_enable, icmp_tx_enable, udp_tx_enable;
  mac_addr_t   arp_mac, icmp_mac, dhcp_mac, udp_mac, dest_mac;
  udp_port_t   dhcp_port, udp_port, dest_port, local_port;

  // expected copies
  ip_addr_t    cfg_static_ip, lease_ip, held_ip;
  mac_addr_t   cfg_mac, held_mac;
  udp_port_t   held_port;

  // {arp, icmp, dhcp, udp} requests and the winner
  logic [3:0]  req_tbl   [8] = '{4'b1111, 4'b0111, 4'b0011, 4'b0001,
                                 4'b0101, 4'b1010, 4'b0010, 4'b1001};
  tx_proto_e   proto_tbl [8] = '{PT_ARP, PT_ICMP, PT_DHCP, PT_UDP,
                                 PT_ICMP, PT_ARP, PT_DHCP, PT_ARP};

  always #2 tx_clock = ~tx_clock;    // 4 ns

  network_top #(.second_ticks(SECOND_TICKS)) u_dut (.*);

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  `include "tb_checks.svh"

  function automatic mac_addr_t rand_mac();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[47:0];
  endfunction

  // new candidate destinations, udp ones tracked while run is low
  task automatic load_dests();
    held_mac  = rand_mac();
    held_ip   = $urandom;
    held_port = udp_port_t'($urandom);
    @(posedge tx_clock);
    arp_mac      <= rand_mac();
    icmp_mac     <= rand_mac();
    dhcp_mac     <= rand_mac();
    icmp_ip      <= $urandom;
    dhcp_ip_dest <= $urandom;
    dhcp_port    <= udp_port_t'($urandom);
    udp_mac      <= held_mac;
    udp_ip       <= held_ip;
    udp_port     <= held_port;
    repeat (2) @(posedge tx_clock);
  endtask

  task automatic check_grant(input tx_proto_e exp_proto);
    mac_addr_t e_mac;
    ip_addr_t  e_ip;
    udp_port_t e_port;
    udp_port_t e_local;
    e_mac   = held_mac;                // udp target unless overridden
    e_ip    = held_ip;
    e_port  = held_port;
    e_local = RADIO_LOCAL_PORT;
    case (exp_proto)
      PT_ARP:  e_mac = arp_mac;
      PT_ICMP: begin
        e_mac = icmp_mac;
        e_ip  = icmp_ip;
      end
      PT_DHCP: begin
        e_mac   = dhcp_mac;
        e_ip    = dhcp_ip_dest;
        e_port  = dhcp_port;
        e_local = DHCP_CLIENT_PORT;
      end
      default: ;
    endcase
    check_proto(tx_protocol, exp_proto, "granted protocol");
    check_bit(arp_tx_enable, exp_proto == PT_ARP, "arp_tx_enable");
    check_bit(icmp_tx_enable, exp_proto == PT_ICMP, "icmp_tx_enable");
    check_bit(udp_tx_enable, exp_proto inside {PT_DHCP, PT_UDP}, "udp_tx_enable");
    check_mac(dest_mac, e_mac, "dest_mac");
    check_ip(dest_ip, e_ip, "dest_ip");
    check_port(dest_port, e_port, "dest_port");
    check_port(local_port, e_local, "local_port");
  endtask

  // one arbitration case, request to release
  task automatic run_grant(input logic [3:0] req, input tx_proto_e exp_proto);
    @(posedge tx_clock);
    {arp_tx_request, icmp_tx_request, dhcp_tx_request, udp_tx_request} <= req;
    @(posedge tx_clock);
    @(negedge tx_clock);
    check_bit(tx_start, 1'b0, "tx_start one cycle after request");
    @(posedge tx_clock);
    {arp_tx_request, icmp_tx_request, dhcp_tx_request, udp_tx_request} <= 4'b0;
    @(negedge tx_clock);
    check_grant(exp_proto);            // 2 cycles after request
    repeat (3) @(negedge tx_clock);    // back-pressure, link not busy
    check_grant(exp_proto);
    @(posedge tx_clock);
    link_busy <= 1'b1;
    @(posedge tx_clock);
    link_busy <= 1'b0;
    @(negedge tx_clock);
    check_bit(tx_start, 1'b0, "tx_start after link_busy");
    check_bit(arp_tx_enable | icmp_tx_enable | udp_tx_enable, 1'b0, "enables after link_busy");
  endtask

  task automatic raise_link();
    @(posedge tx_clock);
    link_up <= 1'b1;
  endtask

  // link loss must restart on the very next edge
  task automatic drop_link();
    @(posedge tx_clock);
    link_up <= 1'b0;
    @(posedge tx_clock);
    @(negedge tx_clock);
    check_state(addr_state, ST_LINK_WAIT, "state after link loss");
    check_bit(dhcp_pending, 1'b1, "dhcp_pending after link loss");
    check_bit(fixed_pending, 1'b1, "fixed_pending after link loss");
  endtask

  initial begin
    int        cycles;
    int        pulses;
    apb_data_t hi_word;
    void'($urandom(4));
    rst_n        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    link_up      = 1'b0;
    link_speed   = 2'b10;              // 1 Gb link
    link_busy    = 1'b0;
    run          = 1'b0;
    dhcp_success = 1'b0;
    dhcp_ip      = '0;
    dhcp_lease   = '0;
    {arp_tx_request, icmp_tx_request, dhcp_tx_request, udp_tx_request} = 4'b0;
    {arp_mac, icmp_mac, dhcp_mac, udp_mac} = '0;
    {icmp_ip, dhcp_ip_dest, udp_ip} = '0;
    {dhcp_port, udp_port} = '0;
    cfg_static_ip = $urandom;
    cfg_mac       = rand_mac();

    repeat (10) @(posedge tx_clock);
    rst_n <= 1'b1;
    @(negedge tx_clock);
    check_bit(dhcp_tx_enable, 1'b0, "dhcp_tx_enable after reset");
    check_bit(dhcp_rx_enable, 1'b0, "dhcp_rx_enable after reset");
    check_bit(tx_start | arp_tx_enable | icmp_tx_enable | udp_tx_enable, 1'b0,
              "transmit outputs after reset");
    check_bit(dhcp_pending & fixed_pending, 1'b1, "pending flags after reset");
    check_bit(speed_1gb, 1'b0, "speed_1gb after reset");
    check_ip(local_ip, '0, "local_ip after reset");

    // ---- register access
    apb_write(REG_CONFIG, 32'h3, 1'b0);
    apb_read(REG_CONFIG, 32'h3, 1'b0);
    apb_write(REG_STATIC_IP, cfg_static_ip, 1'b0);
    apb_read(REG_STATIC_IP, cfg_static_ip, 1'b0);
    apb_write(REG_MAC_LO, cfg_mac[31:0], 1'b0);
    apb_read(REG_MAC_LO, cfg_mac[31:0], 1'b0);
    hi_word = $urandom;                // upper half is not stored
    apb_write(REG_MAC_HI, {hi_word[31:16], cfg_mac[47:32]}, 1'b0);
    apb_read(REG_MAC_HI, {16'd0, cfg_mac[47:32]}, 1'b0);
    apb_read(8'h20, '0, 1'b1);
    apb_write(8'h20, 32'hFFFF_FFFF, 1'b1);
    apb_write(REG_STATUS, 32'hFFFF_FFFF, 1'b1);
    apb_read(REG_CONFIG, 32'h3, 1'b0);
    apb_read(REG_STATUS, {25'd0, 1'b0, 1'b1, 1'b1, 4'(ST_LINK_WAIT)}, 1'b0);

    // ---- arbitration table, then frozen udp target
    load_dests();
    for (int i = 0; i < 8; i++)
      run_grant(req_tbl[i], proto_tbl[i]);
    @(posedge tx_clock);
    run <= 1'b1;
    @(posedge tx_clock);
    udp_mac  <= rand_mac();            // must not reach the header
    udp_ip   <= $urandom;
    udp_port <= udp_port_t'($urandom);
    run_grant(4'b0001, PT_UDP);

    // ---- static address
    apb_write(REG_CONFIG, 32'h1, 1'b0);
    raise_link();
    wait_level(SIG_FIXED_PENDING, 1'b0, 4 * SECOND_TICKS, "static address", cycles);
    check_count(cycles, SECOND_TICKS + 2, "cycles from link up to static address");
    check_state(addr_state, ST_RUNNING, "state with static address");
    check_ip(local_ip, cfg_static_ip, "static local_ip");
    check_bit(dhcp_pending, 1'b1, "dhcp_pending with static address");
    check_bit(speed_1gb, 1'b1, "speed_1gb");
    drop_link();

    // ---- dhcp lease and renewal
    apb_write(REG_CONFIG, 32'h0, 1'b0);
    raise_link();
    wait_level(SIG_DHCP_TX, 1'b1, 3 * SECOND_TICKS, "first DHCP request", cycles);
    lease_ip = $urandom;
    @(posedge tx_clock);
    dhcp_success <= 1'b1;
    dhcp_ip      <= lease_ip;
    dhcp_lease   <= 32'd4;             // renew after 2 s
    @(posedge tx_clock);
    dhcp_success <= 1'b0;
    wait_level(SIG_DHCP_PENDING, 1'b0, 10, "DHCP lease", cycles);
    check_ip(local_ip, lease_ip, "leased local_ip");
    wait_level(SIG_DHCP_TX, 1'b1, 3 * SECOND_TICKS, "renewal request", cycles);
    check_state(addr_state, ST_RENEW_REQ, "state at renewal");
    drop_link();                       // loss with a lease held

    // ---- dhcp timeout, link-local then static fallback
    raise_link();
    count_dhcp_pulses(20 * SECOND_TICKS, pulses);
    check_count(pulses, 4, "DHCP requests before link-local fallback");
    check_state(addr_state, ST_RUNNING, "state after DHCP timeout");
    check_ip(local_ip, {8'd169, 8'd254, cfg_mac[15:0]}, "link-local local_ip");
    check_bit(dhcp_pending, 1'b1, "dhcp_pending after timeout");
    check_seconds(dhcp_seconds, 4'(DHCP_TIMEOUT_S), "dhcp_seconds after timeout");
    drop_link();
    apb_write(REG_CONFIG, 32'h3, 1'b0);
    raise_link();
    count_dhcp_pulses(20 * SECOND_TICKS, pulses);
    check_count(pulses, 4, "DHCP requests before static fallback");
    check_ip(local_ip, cfg_static_ip, "static fallback local_ip");

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== src/network_top.sv ====
// --------------------------------------------------------------------------
// Network control core top. Connects the APB registers, the address
// manager, the transmit arbiter and the destination select.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module network_top
  import net_pkg::*;
#(
  parameter int unsigned second_ticks = SECOND_TICKS_DEFAULT
) (
  input  logic        tx_clock,
  input  logic        rst_n,
  // apb
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  apb_addr_t   paddr,
  input  apb_data_t   pwdata,
  output apb_data_t   prdata,
  output logic        pready,
  output logic        pslverr,
  // link and dhcp results
  input  logic        link_up,
  input  logic [1:0]  link_speed,
  input  logic        dhcp_success,
  input  ip_addr_t    dhcp_ip,
  input  lease_t      dhcp_lease,
  // address status
  output addr_state_e addr_state,
  output ip_addr_t    local_ip,
  output logic        dhcp_tx_enable,
  output logic        dhcp_rx_enable,
  output logic [3:0]  dhcp_seconds,
  output logic        dhcp_pending,
  output logic        fixed_pending,
  output logic        speed_1gb,
  // transmit requests and grant
  input  logic        arp_tx_request,
  input  logic        icmp_tx_request,
  input  logic        dhcp_tx_request,
  input  logic        udp_tx_request,
  input  logic        link_busy,
  output tx_proto_e   tx_protocol,
  output logic        tx_start,
  output logic        arp_tx_enable,
  output logic        icmp_tx_enable,
  output logic        udp_tx_enable,
  // destinations
  input  logic        run,
  input  mac_addr_t   arp_mac,
  input  mac_addr_t   icmp_mac,
  input  mac_addr_t   dhcp_mac,
  input  mac_addr_t   udp_mac,
  input  ip_addr_t    icmp_ip,
  input  ip_addr_t    dhcp_ip_dest,
  input  ip_addr_t    udp_ip,
  input  udp_port_t   dhcp_port,
  input  udp_port_t   udp_port,
  output mac_addr_t   dest_mac,
  output ip_addr_t    dest_ip,
  output udp_port_t   dest_port,
  output udp_port_t   local_port
);

  // configuration from registers to the address manager
  ip_addr_t  static_ip;
  mac_addr_t local_mac;
  logic      use_static;
  logic      dhcp_first;

  net_regs u_regs (
    .tx_clock, .rst_n,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .addr_state, .dhcp_pending, .fixed_pending, .speed_1gb, .local_ip,
    .static_ip, .local_mac, .use_static, .dhcp_first
  );

  addr_manager #(.second_ticks(second_ticks)) u_addr (
    .tx_clock, .rst_n, .link_up, .link_speed,
    .static_ip, .local_mac, .use_static, .dhcp_first,
    .dhcp_success, .dhcp_ip, .dhcp_lease,
    .addr_state, .local_ip, .dhcp_tx_enable, .dhcp_rx_enable,
    .dhcp_seconds, .dhcp_pending, .fixed_pending, .speed_1gb
  );

  tx_arbiter u_arb (
    .tx_clock, .rst_n,
    .arp_tx_request, .icmp_tx_request, .dhcp_tx_request, .udp_tx_request,
    .link_busy, .tx_protocol, .tx_start,
    .arp_tx_enable, .icmp_tx_enable, .udp_tx_enable
  );

  tx_dest_select u_dest (
    .tx_clock, .rst_n, .run, .tx_protocol,
    .arp_mac, .icmp_mac, .dhcp_mac, .udp_mac,
    .icmp_ip, .dhcp_ip_dest, .udp_ip, .dhcp_port, .udp_port,
    .dest_mac, .dest_ip, .dest_port, .local_port
  );

endmodule

// ==== tx/tx_dest_select.sv ====
// --------------------------------------------------------------------------
// Picks destination MAC, IP and port plus the local port for the granted
// protocol. The UDP destination is captured while the radio is stopped
// and frozen once run goes high.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module tx_dest_select
  import net_pkg::*;
(
  input  logic      tx_clock,
  input  logic      rst_n,
  input  logic      run,
  input  tx_proto_e tx_protocol,
  input  mac_addr_t arp_mac,
  input  mac_addr_t icmp_mac,
  input  mac_addr_t dhcp_mac,
  input  mac_addr_t udp_mac,
  input  ip_addr_t  icmp_ip,
  input  ip_addr_t  dhcp_ip_dest,
  input  ip_addr_t  udp_ip,
  input  udp_port_t dhcp_port,
  input  udp_port_t udp_port,
  output mac_addr_t dest_mac,
  output ip_addr_t  dest_ip,
  output udp_port_t dest_port,
  output udp_port_t local_port
);

  mac_addr_t run_mac;   // held udp destination
  ip_addr_t  run_ip;
  udp_port_t run_port;

  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      run_mac  <= '0;
      run_ip   <= '0;
      run_port <= '0;
    end else if (!run) begin         // track until the radio starts
      run_mac  <= udp_mac;
      run_ip   <= udp_ip;
      run_port <= udp_port;
    end
  end

  always_comb begin
    // default is the held udp target, radio port
    dest_mac   = run_mac;
    dest_ip    = run_ip;
    dest_port  = run_port;
    local_port = RADIO_LOCAL_PORT;
    case (tx_protocol)
      PT_ARP:  dest_mac = arp_mac;
      PT_ICMP: begin
        dest_mac = icmp_mac;
        dest_ip  = icmp_ip;
      end
      PT_DHCP: begin
        dest_mac   = dhcp_mac;
        dest_ip    = dhcp_ip_dest;
        dest_port  = dhcp_port;
        local_port = DHCP_CLIENT_PORT;
      end
      default: ;                     // udp
    endcase
  end

endmodule

// ==== tx/tx_arbiter.sv ====
// --------------------------------------------------------------------------
// Fixed-priority transmit arbiter, ARP over ICMP over DHCP over UDP.
// Latches the winner, raises tx_start a cycle later and holds it until
// the link reports busy. Per-engine enables decode from the grant.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module tx_arbiter
  import net_pkg::*;
(
  input  logic      tx_clock,
  input  logic      rst_n,
  input  logic      arp_tx_request,
  input  logic      icmp_tx_request,
  input  logic      dhcp_tx_request,
  input  logic      udp_tx_request,
  input  logic      link_busy,
  output tx_proto_e tx_protocol,
  output logic      tx_start,
  output logic      arp_tx_enable,
  output logic      icmp_tx_enable,
  output logic      udp_tx_enable
);

  logic tx_ready;   // grant taken, start follows

  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      tx_ready    <= 1'b0;
      tx_start    <= 1'b0;
      tx_protocol <= PT_ARP;
    end else if (link_busy) begin
      tx_ready <= 1'b0;              // frame accepted, release
      tx_start <= 1'b0;
    end else if (tx_ready) begin
      tx_start <= 1'b1;              // held until link_busy
    end else if (arp_tx_request || icmp_tx_request ||
                 dhcp_tx_request || udp_tx_request) begin
      tx_ready <= 1'b1;
      if (arp_tx_request)       tx_protocol <= PT_ARP;
      else if (icmp_tx_request) tx_protocol <= PT_ICMP;
      else if (dhcp_tx_request) tx_protocol <= PT_DHCP;
      else                      tx_protocol <= PT_UDP;
    end
  end

  // dhcp and udp share the udp engine
  assign arp_tx_enable  = tx_start && (tx_protocol == PT_ARP);
  assign icmp_tx_enable = tx_start && (tx_protocol == PT_ICMP);
  assign udp_tx_enable  = tx_start && (tx_protocol == PT_DHCP || tx_protocol == PT_UDP);

  // grant is latched a cycle before start and frozen while it is up
  a_proto_stable: assert property (@(posedge tx_clock) disable iff (!rst_n)
    tx_start |-> $stable(tx_protocol));

endmodule

// ==== addr/addr_manager.sv ====
// --------------------------------------------------------------------------
// Address acquisition FSM. Waits for link, settles one second, then takes
// the static address or runs DHCP with retries and a 15 s fallback to the
// static or link-local address. Holds a lease and renews at half time.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module addr_manager
  import net_pkg::*;
#(
  parameter int unsigned second_ticks = SECOND_TICKS_DEFAULT  // at least 40
) (
  input  logic        tx_clock,
  input  logic        rst_n,
  input  logic        link_up,
  input  logic [1:0]  link_speed,
  input  ip_addr_t    static_ip,
  input  mac_addr_t   local_mac,
  input  logic        use_static,
  input  logic        dhcp_first,
  input  logic        dhcp_success,
  input  ip_addr_t    dhcp_ip,
  input  lease_t      dhcp_lease,
  output addr_state_e addr_state,
  output ip_addr_t    local_ip,
  output logic        dhcp_tx_enable,
  output logic        dhcp_rx_enable,
  output logic [3:0]  dhcp_seconds,
  output logic        dhcp_pending,
  output logic        fixed_pending,
  output logic        speed_1gb
);

  localparam int unsigned TW          = $clog2(second_ticks);
  localparam int unsigned RETRY_TICKS = second_ticks / 20;    // 50 ms

  addr_state_e   state;
  logic [TW-1:0] sec_timer;
  logic          sec_tick;     // end of a second
  renew_cnt_t    renew_cnt;    // seconds, or ticks while in retry
  renew_cnt_t    lease_renew;
  ip_addr_t      fixed_ip;     // address to use if DHCP gives up

  assign addr_state     = state;
  assign sec_tick       = (sec_timer == '0);
  assign dhcp_tx_enable = (state == ST_DHCP_REQ) || (state == ST_RENEW_REQ);
  assign lease_renew    = (dhcp_lease == '0) ? renew_cnt_t'(DEFAULT_RENEW_S)
                                             : renew_cnt_t'(dhcp_lease >> 1);

  // ------------------------------------------------------------------------
  // one second timer, aligned to link up
  // ------------------------------------------------------------------------
  always_ff @(posedge tx_clock) begin
    if (!rst_n)
      sec_timer <= '0;
    else if (state <= ST_LINK_WAIT || sec_tick)
      sec_timer <= TW'(second_ticks - 1);
    else
      sec_timer <= sec_timer - 1'b1;
  end

  // fallback choice, taken with the rest of the config when settle ends
  always_ff @(posedge tx_clock) begin
    if (state == ST_SETTLE && sec_tick)
      fixed_ip <= use_static ? static_ip : {APIPA_PREFIX, local_mac[15:0]};
  end

  // ------------------------------------------------------------------------
  // state machine
  // ------------------------------------------------------------------------
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      state          <= ST_IDLE;
      local_ip       <= '0;
      dhcp_rx_enable <= 1'b0;
      dhcp_seconds   <= '0;
      dhcp_pending   <= 1'b1;
      fixed_pending  <= 1'b1;
      speed_1gb      <= 1'b0;
      renew_cnt      <= '0;
    end else if (state > ST_LINK_WAIT && !link_up) begin
      state          <= ST_LINK_WAIT;    // link lost, start over
      dhcp_pending   <= 1'b1;
      fixed_pending  <= 1'b1;
      dhcp_rx_enable <= 1'b0;
    end else begin
      case (state)
        ST_IDLE:      state <= ST_LINK_WAIT;
        ST_LINK_WAIT: if (link_up) begin
          speed_1gb <= link_speed[1];
          state     <= ST_SETTLE;
        end
        ST_SETTLE: if (sec_tick) begin
          if (use_static && !dhcp_first) begin
            local_ip <= static_ip;
            state    <= ST_RUNNING;
          end else begin
            local_ip     <= '0;           // 0.0.0.0 while asking
            dhcp_seconds <= '0;
            state        <= ST_DHCP_REQ;
          end
        end
        ST_DHCP_REQ: begin               // tx pulse comes from the state
          dhcp_rx_enable <= 1'b1;
          state          <= ST_DHCP_WAIT;
        end
        ST_DHCP_WAIT:
          if (dhcp_success) begin
            local_ip     <= dhcp_ip;
            dhcp_pending <= 1'b0;
            dhcp_seconds <= '0;
            renew_cnt    <= lease_renew;
            state        <= ST_RENEW_WAIT;
          end else if (sec_tick) begin
            dhcp_seconds <= dhcp_seconds + 1'b1;
            renew_cnt    <= renew_cnt_t'(RETRY_TICKS - 1);
            if (dhcp_seconds inside {4'd0, 4'd2, 4'd6})   // ends of 1, 3, 7 s
              state <= ST_DHCP_RETRY;
            else if (dhcp_seconds == 4'(DHCP_TIMEOUT_S - 1)) begin
              local_ip <= fixed_ip;       // give up on DHCP
              state    <= ST_RUNNING;
            end
          end
        ST_DHCP_RETRY: begin
          dhcp_rx_enable <= 1'b0;
          if (renew_cnt == '0) state <= ST_DHCP_REQ;
          else                 renew_cnt <= renew_cnt - 1'b1;
        end
        ST_RUNNING: begin
          dhcp_rx_enable <= 1'b0;
          fixed_pending  <= 1'b0;
        end
        ST_RENEW_WAIT: begin             // lease held, count to renewal
          dhcp_rx_enable <= 1'b0;
          if (renew_cnt == '0) state <= ST_RENEW_REQ;
          else if (sec_tick)   renew_cnt <= renew_cnt - 1'b1;
        end
        ST_RENEW_REQ: begin
          dhcp_rx_enable <= 1'b1;
          renew_cnt      <= renew_cnt_t'(RENEW_ACK_WAIT_S);
          state          <= ST_RENEW_ACK;
        end
        ST_RENEW_ACK:
          if (dhcp_success) begin
            local_ip  <= dhcp_ip;
            renew_cnt <= lease_renew;
            state     <= ST_RENEW_WAIT;
          end else if (sec_tick) begin
            if (renew_cnt == '0) begin   // no ack, back off
              renew_cnt <= renew_cnt_t'(RENEW_RETRY_S);
              state     <= ST_RENEW_WAIT;
            end else
              renew_cnt <= renew_cnt - 1'b1;
          end
        default: state <= ST_IDLE;
      endcase
    end
  end

  a_tx_pulse: assert property (@(posedge tx_clock) disable iff (!rst_n)
    dhcp_tx_enable |=> !dhcp_tx_enable);
  a_state_legal: assert property (@(posedge tx_clock) disable iff (!rst_n)
    !$isunknown(state) && state <= ST_RENEW_ACK);

endmodule

// ==== src/net_regs.sv ====
// --------------------------------------------------------------------------
// APB slave holding the static address, MAC and address-mode bits, plus
// a read-only view of the address manager status. No wait states.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module net_regs
  import net_pkg::*;
(
  input  logic        tx_clock,
  input  logic        rst_n,
  // apb
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  apb_addr_t   paddr,
  input  apb_data_t   pwdata,
  output apb_data_t   prdata,
  output logic        pready,
  output logic        pslverr,
  // status in
  input  addr_state_e addr_state,
  input  logic        dhcp_pending,
  input  logic        fixed_pending,
  input  logic        speed_1gb,
  input  ip_addr_t    local_ip,
  // configuration out
  output ip_addr_t    static_ip,
  output mac_addr_t   local_mac,
  output logic        use_static,
  output logic        dhcp_first
);

  logic access;     // second phase of a transfer
  logic mapped;
  logic read_only;
  logic wr_en;

  assign access  = psel && penable;
  assign pready  = 1'b1;           // never stalls
  assign pslverr = access && (!mapped || (pwrite && read_only));
  assign wr_en   = access && pwrite && mapped && !read_only;

  // address decode and readback mux
  always_comb begin
    mapped    = 1'b1;
    read_only = 1'b0;
    prdata    = '0;
    case (paddr)
      REG_CONFIG:    prdata = {30'd0, dhcp_first, use_static};
      REG_STATIC_IP: prdata = static_ip;
      REG_MAC_LO:    prdata = local_mac[31:0];
      REG_MAC_HI:    prdata = {16'd0, local_mac[47:32]};
      REG_STATUS: begin
        read_only = 1'b1;
        prdata    = {25'd0, speed_1gb, fixed_pending, dhcp_pending, addr_state};
      end
      REG_LOCAL_IP: begin
        read_only = 1'b1;
        prdata    = local_ip;
      end
      default:       mapped = 1'b0;   // unmapped, flagged by pslverr
    endcase
  end

  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      use_static <= 1'b0;
      dhcp_first <= 1'b0;
      static_ip  <= '0;
      local_mac  <= '0;
    end else if (wr_en) begin
      case (paddr)
        REG_CONFIG: begin
          use_static <= pwdata[0];
          dhcp_first <= pwdata[1];
        end
        REG_STATIC_IP: static_ip         <= pwdata;
        REG_MAC_LO:    local_mac[31:0]   <= pwdata;
        REG_MAC_HI:    local_mac[47:32]  <= pwdata[15:0];  // upper half only
        default:       ;
      endcase
    end
  end

  // access phase always follows a select
  a_penable_psel: assert property (@(posedge tx_clock) disable iff (!rst_n)
    penable |-> psel);

endmodule

// ==== common/net_pkg.sv ====
// --------------------------------------------------------------------------
// Shared widths, types, encodings and constants for the network control
// core. Every RTL block pulls this in with a wildcard import.
// --------------------------------------------------------------------------
package net_pkg;

  // widths with a meaning
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [31:0] lease_t;      // seconds, as the server sends it
  typedef logic [17:0] renew_cnt_t;  // seconds left until renewal
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // transmit protocol, lower value wins arbitration
  typedef enum logic [1:0] {
    PT_ARP  = 2'd0,
    PT_ICMP = 2'd1,
    PT_DHCP = 2'd2,
    PT_UDP  = 2'd3
  } tx_proto_e;

  // address manager states, ordering matters for the link-loss check
  typedef enum logic [3:0] {
    ST_IDLE       = 4'd0,
    ST_LINK_WAIT  = 4'd1,
    ST_SETTLE     = 4'd2,
    ST_DHCP_REQ   = 4'd3,
    ST_DHCP_WAIT  = 4'd4,
    ST_DHCP_RETRY = 4'd5,
    ST_RUNNING    = 4'd6,
    ST_RENEW_WAIT = 4'd7,
    ST_RENEW_REQ  = 4'd8,
    ST_RENEW_ACK  = 4'd9
  } addr_state_e;

  // ------------------------------------------------------------------------
  // timing
  // ------------------------------------------------------------------------
  localparam int unsigned SECOND_TICKS_DEFAULT = 2_500_000;  // one second of tx_clock
  localparam int unsigned DHCP_TIMEOUT_S       = 15;
  localparam int unsigned DEFAULT_RENEW_S      = 43_200;     // lease of 0 means 12 h
  localparam int unsigned RENEW_ACK_WAIT_S     = 20;
  localparam int unsigned RENEW_RETRY_S        = 300;

  // ports and address constants
  localparam udp_port_t    DHCP_CLIENT_PORT = 16'd68;
  localparam udp_port_t    RADIO_LOCAL_PORT = 16'd1024;
  localparam logic [15:0]  APIPA_PREFIX     = {8'd169, 8'd254};

  // ------------------------------------------------------------------------
  // register map
  // ------------------------------------------------------------------------
  localparam apb_addr_t REG_CONFIG    = 8'h00;  // [0] use_static, [1] dhcp_first
  localparam apb_addr_t REG_STATIC_IP = 8'h04;
  localparam apb_addr_t REG_MAC_LO    = 8'h08;
  localparam apb_addr_t REG_MAC_HI    = 8'h0C;
  localparam apb_addr_t REG_STATUS    = 8'h10;  // read only
  localparam apb_addr_t REG_LOCAL_IP  = 8'h14;  // read only

endpackage
